/* common/fcfg_consts.svh */
// --------------------------------------------------
// Filter-condition loader constants
// Widths, FIFO sizing, setup window and slot numbers
// --------------------------------------------------
`ifndef FCFG_CONSTS_SVH
`define FCFG_CONSTS_SVH

// Memory packet widths
`define FCFG_DATA_W             32
`define FCFG_OFFSET_W           32
`define FCFG_SHIFT_W            5
`define FCFG_BUF_CLASS_W        3

// Buffer class codes that carry setup words
`define FCFG_CLASS_CU_SETUP     1
`define FCFG_CLASS_ENGINE_SETUP 2

// Setup block and record field widths
`define FCFG_SEQ_WIDTH          16
`define FCFG_NUM_FIELDS         4
`define FCFG_OP_W               4
`define FCFG_FLAGS_W            7

// Route identifier widths
`define FCFG_CU_W               2
`define FCFG_BUNDLE_W           2
`define FCFG_LANE_W             2
`define FCFG_BUFFER_W           2
`define FCFG_ENGINE_W           3
`define FCFG_MODULE_W           2

// FIFO sizing
`define FCFG_FIFO_DEPTH         16
`define FCFG_PROG_THRESH        8

// Word slots inside a setup block
`define FCFG_SLOT_OP            0
`define FCFG_SLOT_FILTER_MASK   1
`define FCFG_SLOT_CONST_MASK    2
`define FCFG_SLOT_CONST_VALUE   3
`define FCFG_SLOT_OPS_MASK      4
`define FCFG_SLOT_FLAGS         5
`define FCFG_SLOT_ROUTE_IF      6
`define FCFG_SLOT_ROUTE_ELSE    7
`define FCFG_SLOT_ROUTE_EXT     8
`define FCFG_SLOT_LAST          (`FCFG_SEQ_WIDTH - 1)

`endif

/* common/mem_pkt_pkg.sv */
// --------------------------------------------------
// Memory response packet types
// Fields of one word returned by the memory side
// --------------------------------------------------
`include "fcfg_consts.svh"

package mem_pkt_pkg;

    // ----------------------------------------------
    // Scalar types
    // ----------------------------------------------
    // One payload word
    typedef logic [`FCFG_DATA_W-1:0] data_word_t;

    // Byte offset of the packet inside its buffer
    typedef logic [`FCFG_OFFSET_W-1:0] offset_t;

    // Right shift that turns an offset into a word index
    typedef logic [`FCFG_SHIFT_W-1:0] shift_amt_t;

    // Word index after the shift, same width as the offset
    typedef logic [`FCFG_OFFSET_W-1:0] seq_index_t;

    // Buffer class, setup codes live in the constants header
    typedef logic [`FCFG_BUF_CLASS_W-1:0] buf_class_t;

    // ----------------------------------------------
    // Packet
    // ----------------------------------------------
    typedef struct packed {
        buf_class_t buf_class;
        offset_t    offset;
        shift_amt_t shift_amt;
        data_word_t data;
    } mem_pkt_t;

endpackage

/* common/filter_cfg_pkg.sv */
// --------------------------------------------------
// Filter-condition configuration types
// Record layout, flags and routes of one engine
// --------------------------------------------------
`include "fcfg_consts.svh"

package filter_cfg_pkg;

    // ----------------------------------------------
    // Scalar types
    // ----------------------------------------------
    typedef logic [`FCFG_OP_W-1:0] filter_op_t;

    // One bit per data field
    typedef logic [`FCFG_NUM_FIELDS-1:0] field_mask_t;

    // One field mask per field
    typedef logic [`FCFG_NUM_FIELDS*`FCFG_NUM_FIELDS-1:0] ops_mask_t;

    // Which word of a setup block is being loaded
    typedef logic [`FCFG_SEQ_WIDTH-1:0] slot_onehot_t;

    // ----------------------------------------------
    // Route target
    // ----------------------------------------------
    typedef struct packed {
        logic [`FCFG_CU_W-1:0]     cu;
        logic [`FCFG_BUNDLE_W-1:0] bundle;
        logic [`FCFG_LANE_W-1:0]   lane;
        logic [`FCFG_BUFFER_W-1:0] buffer;
        logic [`FCFG_ENGINE_W-1:0] engine;
        logic [`FCFG_MODULE_W-1:0] module_id;
    } filter_route_t;

    // Flags, break_flag sits in bit 0
    typedef struct packed {
        logic conditional_flag;
        logic ternary_flag;
        logic continue_flag;
        logic filter_pass;
        logic filter_post;
        logic break_pass;
        logic break_flag;
    } filter_flags_t;

    // ----------------------------------------------
    // Full configuration record
    // ----------------------------------------------
    typedef struct packed {
        filter_op_t             filter_op;
        field_mask_t            filter_mask;
        field_mask_t            const_mask;
        mem_pkt_pkg::data_word_t const_value;
        ops_mask_t              ops_mask;
        filter_flags_t          flags;
        filter_route_t          route_if;
        filter_route_t          route_else;
    } filter_cfg_t;

endpackage

/* design/sync_fifo.sv */
// --------------------------------------------------
// Synchronous FIFO
// Registered read with valid, plus empty, full and
// programmable-full flags
// --------------------------------------------------
`include "fcfg_consts.svh"

module sync_fifo #(
    parameter int width = 32,
    parameter int depth = 16
) (
    input  logic             ap_clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [width-1:0] din,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Pointer step with wrap for any depth
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // Writes to a full FIFO and reads from an empty one are ignored
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // ----------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (!do_wr && do_rd) begin
                count <= count - 1'b1;
            end
        end
    end

    // ----------------------------------------------
    // Storage and registered read
    // ----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    assign empty     = (count == '0);
    assign full      = (count == cnt_w'(depth));
    assign prog_full = (count >= cnt_w'(`FCFG_PROG_THRESH));

endmodule

/* cfg_loader/setup_packet_filter.sv */
// --------------------------------------------------
// Setup packet filter
// Keeps setup-class packets inside this engine's
// window of words and pushes them to the response FIFO
// --------------------------------------------------
`include "fcfg_consts.svh"

module setup_packet_filter #(
    parameter int cfg_slot = 0
) (
    input  logic                  ap_clk,
    input  logic                  rst_n,
    input  logic                  rsp_valid,
    input  mem_pkt_pkg::mem_pkt_t rsp_pkt,
    output logic                  push,
    output mem_pkt_pkg::mem_pkt_t push_pkt
);

    // Window of sequence indices owned by this engine
    localparam mem_pkt_pkg::seq_index_t seq_min =
        mem_pkt_pkg::seq_index_t'(cfg_slot * `FCFG_SEQ_WIDTH);
    localparam mem_pkt_pkg::seq_index_t seq_max =
        mem_pkt_pkg::seq_index_t'((cfg_slot + 1) * `FCFG_SEQ_WIDTH);

    logic                    valid_r;
    mem_pkt_pkg::mem_pkt_t   pkt_r;
    mem_pkt_pkg::seq_index_t seq_idx;
    logic                    class_ok;
    logic                    in_window;

    // Input stage
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= rsp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        pkt_r <= rsp_pkt;
    end

    assign seq_idx = pkt_r.offset >> pkt_r.shift_amt;

    // Either of the two setup classes
    assign class_ok =
        (pkt_r.buf_class == mem_pkt_pkg::buf_class_t'(`FCFG_CLASS_CU_SETUP)) |
        (pkt_r.buf_class == mem_pkt_pkg::buf_class_t'(`FCFG_CLASS_ENGINE_SETUP));

    assign in_window = (seq_idx >= seq_min) & (seq_idx < seq_max);

    assign push     = valid_r & class_ok & in_window;
    assign push_pkt = pkt_r;

endmodule

/* cfg_loader/cfg_word_sequencer.sv */
// --------------------------------------------------
// Setup word sequencer
// Pops the response FIFO and tags each word with its
// one-hot slot, pulses complete after the last slot
// --------------------------------------------------
`include "fcfg_consts.svh"

module cfg_word_sequencer #(
    parameter int cfg_slot = 0
) (
    input  logic                        ap_clk,
    input  logic                        rst_n,
    input  logic                        rsp_rd_en,
    input  logic                        fifo_empty,
    input  logic                        fifo_valid,
    input  mem_pkt_pkg::mem_pkt_t       fifo_pkt,
    input  logic                        cfg_prog_full,
    output logic                        pop,
    output mem_pkt_pkg::data_word_t     word,
    output filter_cfg_pkg::slot_onehot_t word_slot,
    output logic                        word_valid,
    output logic                        complete
);

    localparam mem_pkt_pkg::seq_index_t seq_base =
        mem_pkt_pkg::seq_index_t'(cfg_slot * `FCFG_SEQ_WIDTH);

    mem_pkt_pkg::seq_index_t seq_idx;
    logic                    block_open;
    logic                    is_start;

    assign seq_idx  = fifo_pkt.offset >> fifo_pkt.shift_amt;
    assign is_start = (seq_idx == seq_base);

    // Open from slot 0 to slot 14; once slot 15 is loaded the block
    // is done and the next word may already start a new one
    assign block_open = |word_slot[`FCFG_SLOT_LAST-1:0];

    // Hold off while a record is being closed or the config side is backed up
    assign pop = ~fifo_empty & rsp_rd_en & ~complete & ~cfg_prog_full;

    // ----------------------------------------------
    // Slot tracking
    // ----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            word_slot  <= '0;
            word_valid <= 1'b0;
            complete   <= 1'b0;
        end else begin
            word_valid <= fifo_valid;
            complete   <= word_slot[`FCFG_SLOT_LAST];
            if (fifo_valid) begin
                if (block_open) begin
                    word_slot <= word_slot << 1;
                end else if (is_start) begin
                    word_slot <= filter_cfg_pkg::slot_onehot_t'(1);
                end else begin
                    // Stray word outside a block
                    word_slot <= '0;
                end
            end else if (word_slot[`FCFG_SLOT_LAST]) begin
                // Last slot falls back to idle
                word_slot <= '0;
            end
        end
    end

    // Payload word follows its slot
    always_ff @(posedge ap_clk) begin
        if (fifo_valid) begin
            word <= fifo_pkt.data;
        end
    end

endmodule

/* cfg_loader/cfg_field_decoder.sv */
// --------------------------------------------------
// Configuration field decoder
// Builds the filter-condition record slot by slot and
// writes it out once the block is complete
// --------------------------------------------------
`include "fcfg_consts.svh"

module cfg_field_decoder (
    input  logic                         ap_clk,
    input  logic                         rst_n,
    input  mem_pkt_pkg::data_word_t      word,
    input  filter_cfg_pkg::slot_onehot_t word_slot,
    input  logic                         word_valid,
    input  logic                         complete,
    output logic                         cfg_wr,
    output filter_cfg_pkg::filter_cfg_t  cfg_rec
);

    // Bit positions inside the route words
    localparam int bundle_lsb      = `FCFG_CU_W;
    localparam int lane_lsb        = bundle_lsb + `FCFG_BUNDLE_W;
    localparam int buffer_lsb      = lane_lsb + `FCFG_LANE_W;
    localparam int if_module_lsb   = `FCFG_ENGINE_W;
    localparam int else_engine_lsb = if_module_lsb + `FCFG_MODULE_W;
    localparam int else_module_lsb = else_engine_lsb + `FCFG_ENGINE_W;

    filter_cfg_pkg::filter_cfg_t rec;

    // cu, bundle, lane and buffer from the low bits of a route word
    function automatic filter_cfg_pkg::filter_route_t set_route_lo(
        input filter_cfg_pkg::filter_route_t rt,
        input mem_pkt_pkg::data_word_t       w
    );
        filter_cfg_pkg::filter_route_t r;
        r        = rt;
        r.cu     = w[`FCFG_CU_W-1:0];
        r.bundle = w[bundle_lsb +: `FCFG_BUNDLE_W];
        r.lane   = w[lane_lsb +: `FCFG_LANE_W];
        r.buffer = w[buffer_lsb +: `FCFG_BUFFER_W];
        return r;
    endfunction

    // ----------------------------------------------
    // Field update, slots 9 to 15 carry nothing
    // ----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (word_valid) begin
            case (1'b1)
                word_slot[`FCFG_SLOT_OP]: begin
                    rec.filter_op <= word[`FCFG_OP_W-1:0];
                end
                word_slot[`FCFG_SLOT_FILTER_MASK]: begin
                    rec.filter_mask <= word[`FCFG_NUM_FIELDS-1:0];
                end
                word_slot[`FCFG_SLOT_CONST_MASK]: begin
                    rec.const_mask <= word[`FCFG_NUM_FIELDS-1:0];
                end
                word_slot[`FCFG_SLOT_CONST_VALUE]: begin
                    rec.const_value <= word;
                end
                word_slot[`FCFG_SLOT_OPS_MASK]: begin
                    rec.ops_mask <= word[`FCFG_NUM_FIELDS*`FCFG_NUM_FIELDS-1:0];
                end
                word_slot[`FCFG_SLOT_FLAGS]: begin
                    rec.flags <= word[`FCFG_FLAGS_W-1:0];
                end
                word_slot[`FCFG_SLOT_ROUTE_IF]: begin
                    rec.route_if <= set_route_lo(rec.route_if, word);
                end
                word_slot[`FCFG_SLOT_ROUTE_ELSE]: begin
                    rec.route_else <= set_route_lo(rec.route_else, word);
                end
                word_slot[`FCFG_SLOT_ROUTE_EXT]: begin
                    rec.route_if.engine      <= word[`FCFG_ENGINE_W-1:0];
                    rec.route_if.module_id   <= word[if_module_lsb +: `FCFG_MODULE_W];
                    rec.route_else.engine    <= word[else_engine_lsb +: `FCFG_ENGINE_W];
                    rec.route_else.module_id <= word[else_module_lsb +: `FCFG_MODULE_W];
                end
                default: begin
                    rec <= rec;
                end
            endcase
        end
    end

    // ----------------------------------------------
    // Record write
    // ----------------------------------------------
    // Snapshot taken on complete, before a new block's slot 0 lands
    always_ff @(posedge ap_clk) begin
        if (complete) begin
            cfg_rec <= rec;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            cfg_wr <= 1'b0;
        end else begin
            cfg_wr <= complete;
        end
    end

endmodule

/* cfg_loader/filter_cond_cfg_loader.sv */
// --------------------------------------------------
// Filter-condition configuration loader
// Filters setup packets, decodes 16-word blocks into
// records and queues them for the engine
// --------------------------------------------------
`include "fcfg_consts.svh"

module filter_cond_cfg_loader #(
    parameter int cfg_slot = 0
) (
    input  logic                        ap_clk,
    input  logic                        rst_n,
    input  logic                        rsp_valid,
    input  mem_pkt_pkg::mem_pkt_t       rsp_pkt,
    input  logic                        rsp_rd_en,
    input  logic                        cfg_rd_en,
    output logic                        cfg_valid,
    output filter_cfg_pkg::filter_cfg_t cfg_out,
    output logic                        rsp_full,
    output logic                        rsp_prog_full,
    output logic                        cfg_empty
);

    logic                         rsp_rd_en_r;
    logic                         cfg_rd_en_r;
    logic                         rsp_push;
    mem_pkt_pkg::mem_pkt_t        rsp_push_pkt;
    logic                         rsp_pop;
    mem_pkt_pkg::mem_pkt_t        rsp_dout;
    logic                         rsp_dvalid;
    logic                         rsp_empty;
    mem_pkt_pkg::data_word_t      word;
    filter_cfg_pkg::slot_onehot_t word_slot;
    logic                         word_valid;
    logic                         complete;
    logic                         cfg_wr;
    filter_cfg_pkg::filter_cfg_t  cfg_rec;
    logic                         cfg_pop;
    filter_cfg_pkg::filter_cfg_t  cfg_dout;
    logic                         cfg_dvalid;
    logic                         cfg_prog_full;

    // ----------------------------------------------
    // Read enables and output stage
    // ----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            rsp_rd_en_r <= 1'b0;
            cfg_rd_en_r <= 1'b0;
            cfg_valid   <= 1'b0;
        end else begin
            rsp_rd_en_r <= rsp_rd_en;
            cfg_rd_en_r <= cfg_rd_en;
            cfg_valid   <= cfg_dvalid;
        end
    end

    always_ff @(posedge ap_clk) begin
        cfg_out <= cfg_dout;
    end

    assign cfg_pop = ~cfg_empty & cfg_rd_en_r;

    // ----------------------------------------------
    // Response path
    // ----------------------------------------------
    setup_packet_filter #(
        .cfg_slot (cfg_slot)
    ) u_filter (
        .ap_clk    (ap_clk),
        .rst_n     (rst_n),
        .rsp_valid (rsp_valid),
        .rsp_pkt   (rsp_pkt),
        .push      (rsp_push),
        .push_pkt  (rsp_push_pkt)
    );

    sync_fifo #(
        .width ($bits(mem_pkt_pkg::mem_pkt_t)),
        .depth (`FCFG_FIFO_DEPTH)
    ) u_rsp_fifo (
        .ap_clk    (ap_clk),
        .rst_n     (rst_n),
        .wr_en     (rsp_push),
        .din       (rsp_push_pkt),
        .rd_en     (rsp_pop),
        .dout      (rsp_dout),
        .valid     (rsp_dvalid),
        .empty     (rsp_empty),
        .full      (rsp_full),
        .prog_full (rsp_prog_full)
    );

    cfg_word_sequencer #(
        .cfg_slot (cfg_slot)
    ) u_sequencer (
        .ap_clk        (ap_clk),
        .rst_n         (rst_n),
        .rsp_rd_en     (rsp_rd_en_r),
        .fifo_empty    (rsp_empty),
        .fifo_valid    (rsp_dvalid),
        .fifo_pkt      (rsp_dout),
        .cfg_prog_full (cfg_prog_full),
        .pop           (rsp_pop),
        .word          (word),
        .word_slot     (word_slot),
        .word_valid    (word_valid),
        .complete      (complete)
    );

    // ----------------------------------------------
    // Record path
    // ----------------------------------------------
    cfg_field_decoder u_decoder (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .word       (word),
        .word_slot  (word_slot),
        .word_valid (word_valid),
        .complete   (complete),
        .cfg_wr     (cfg_wr),
        .cfg_rec    (cfg_rec)
    );

    sync_fifo #(
        .width ($bits(filter_cfg_pkg::filter_cfg_t)),
        .depth (`FCFG_FIFO_DEPTH)
    ) u_cfg_fifo (
        .ap_clk    (ap_clk),
        .rst_n     (rst_n),
        .wr_en     (cfg_wr),
        .din       (cfg_rec),
        .rd_en     (cfg_pop),
        .dout      (cfg_dout),
        .valid     (cfg_dvalid),
        .empty     (cfg_empty),
        .full      (),
        .prog_full (cfg_prog_full)
    );

endmodule

/* sim/tb_cfg_tasks.svh */
// --------------------------------------------------
// Testbench tasks for the config loader
// Packet and block stimulus, expected record model
// --------------------------------------------------
`ifndef TB_CFG_TASKS_SVH
`define TB_CFG_TASKS_SVH

// Record that a block in blk_words must decode to
function automatic filter_cfg_pkg::filter_cfg_t expect_record();
    filter_cfg_pkg::filter_cfg_t r;
    r.filter_op            = blk_words[0][3:0];
    r.filter_mask          = blk_words[1][3:0];
    r.const_mask           = blk_words[2][3:0];
    r.const_value          = blk_words[3];
    r.ops_mask             = blk_words[4][15:0];
    r.flags                = blk_words[5][6:0];
    r.route_if.cu          = blk_words[6][1:0];
    r.route_if.bundle      = blk_words[6][3:2];
    r.route_if.lane        = blk_words[6][5:4];
    r.route_if.buffer      = blk_words[6][7:6];
    r.route_else.cu        = blk_words[7][1:0];
    r.route_else.bundle    = blk_words[7][3:2];
    r.route_else.lane      = blk_words[7][5:4];
    r.route_else.buffer    = blk_words[7][7:6];
    // Slot 8 packs both engine and module fields
    r.route_if.engine      = blk_words[8][2:0];
    r.route_if.module_id   = blk_words[8][4:3];
    r.route_else.engine    = blk_words[8][7:5];
    r.route_else.module_id = blk_words[8][9:8];
    return r;
endfunction

task automatic refresh_head();
    exp_count = exp_q.size();
    exp_head  = (exp_count != 0) ? exp_q[0] : '0;
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge ap_clk);
        #1;
    end
endtask

// One packet for one cycle, held back while the response FIFO fills up
task automatic drive_packet(input mem_pkt_pkg::buf_class_t cls,
                            input mem_pkt_pkg::seq_index_t idx,
                            input mem_pkt_pkg::shift_amt_t sh,
                            input mem_pkt_pkg::data_word_t data);
    while (rsp_prog_full) begin
        idle_cycles(1);
    end
    rsp_valid         = 1'b1;
    rsp_pkt.buf_class = cls;
    rsp_pkt.offset    = idx << sh;
    rsp_pkt.shift_amt = sh;
    rsp_pkt.data      = data;
    idle_cycles(1);
    rsp_valid = 1'b0;
endtask

// Wrong class, or an index just outside the window
task automatic inject_strays();
    drive_packet(3'd3, base_idx + 1, 0, $urandom);
    drive_packet(3'd0, base_idx, 0, $urandom);
    drive_packet(`FCFG_CLASS_CU_SETUP, base_idx - 1, 0, $urandom);
    drive_packet(`FCFG_CLASS_ENGINE_SETUP, base_idx + 16, 0, $urandom);
endtask

task automatic load_block(input mem_pkt_pkg::buf_class_t cls,
                          input mem_pkt_pkg::shift_amt_t sh,
                          input bit mix_strays);
    int i;
    for (i = 0; i < 16; i++) begin
        blk_words[i] = $urandom;
    end
    exp_q.push_back(expect_record());
    refresh_head();
    for (i = 0; i < 16; i++) begin
        drive_packet(cls, base_idx + i, sh, blk_words[i]);
        if (mix_strays && (i % 6 == 3)) begin
            inject_strays();
        end
        idle_cycles($urandom % 3);
    end
endtask

task automatic wait_drained();
    while (exp_count != 0) begin
        idle_cycles(1);
    end
endtask

`endif

/* sim/tb_filter_cond_cfg.sv */
// --------------------------------------------------
// Testbench for the filter-condition config loader
// Setup blocks in, decoded records checked on cfg_out
// --------------------------------------------------
`include "fcfg_consts.svh"

module tb_filter_cond_cfg;

    localparam int slot_idx = 2;
    localparam int base_idx = slot_idx * 16;
    // About ten times the length of the whole sequence
    localparam int max_cycles = 4000;

    logic                        ap_clk;
    logic                        rst_n;
    logic                        rsp_valid;
    mem_pkt_pkg::mem_pkt_t       rsp_pkt;
    logic                        rsp_rd_en;
    logic                        cfg_rd_en;
    logic                        cfg_valid;
    filter_cfg_pkg::filter_cfg_t cfg_out;
    logic                        rsp_full;
    logic                        rsp_prog_full;
    logic                        cfg_empty;

    mem_pkt_pkg::data_word_t     blk_words [16];
    filter_cfg_pkg::filter_cfg_t exp_q [$];
    filter_cfg_pkg::filter_cfg_t exp_head;
    int                          exp_count;
    logic                        started;
    logic                        bp_done;
    int                          cycle_cnt;

    task automatic stop_run_failed();
        $display("Test FAILED");
        $fatal(1, "run stopped after a failed check");
    endtask

    task automatic value_mismatch(input string name, input logic [127:0] exp_v,
                                  input logic [127:0] act_v);
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, act_v);
        stop_run_failed();
    endtask

    task automatic plain_failure(input string what);
        $display("%0t %s", $time, what);
        stop_run_failed();
    endtask

    `include "tb_cfg_tasks.svh"

    filter_cond_cfg_loader #(
        .cfg_slot (slot_idx)
    ) DUT (
        .ap_clk        (ap_clk),
        .rst_n         (rst_n),
        .rsp_valid     (rsp_valid),
        .rsp_pkt       (rsp_pkt),
        .rsp_rd_en     (rsp_rd_en),
        .cfg_rd_en     (cfg_rd_en),
        .cfg_valid     (cfg_valid),
        .cfg_out       (cfg_out),
        .rsp_full      (rsp_full),
        .rsp_prog_full (rsp_prog_full),
        .cfg_empty     (cfg_empty)
    );

    always #4 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            plain_failure("timeout, expected records did not arrive in time");
        end
    end

    // Retire the expected record that cfg_valid just presented
    always @(posedge ap_clk) begin
        if (rst_n && cfg_valid && exp_count != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    assert property (@(posedge ap_clk) disable iff (!rst_n) !started |-> !cfg_valid)
        else value_mismatch("cfg_valid", 0, $sampled(cfg_valid));
    assert property (@(posedge ap_clk) disable iff (!rst_n) !started |-> cfg_empty)
        else value_mismatch("cfg_empty", 1, $sampled(cfg_empty));
    assert property (@(posedge ap_clk) disable iff (!rst_n) !started |-> !rsp_prog_full)
        else value_mismatch("rsp_prog_full", 0, $sampled(rsp_prog_full));
    // Sender backs off at prog_full so the response FIFO never fills
    assert property (@(posedge ap_clk) disable iff (!rst_n) !rsp_full)
        else value_mismatch("rsp_full", 0, $sampled(rsp_full));
    assert property (@(posedge ap_clk) disable iff (!rst_n) cfg_valid |-> exp_count != 0)
        else plain_failure("cfg_valid raised with no record expected");
    // Stalled reader sees no record three cycles on
    assert property (@(posedge ap_clk) disable iff (!rst_n) !cfg_rd_en |-> ##3 !cfg_valid)
        else value_mismatch("cfg_valid", 0, $sampled(cfg_valid));

    assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> cfg_out.filter_op == exp_head.filter_op)
        else value_mismatch("cfg_out.filter_op", $sampled(exp_head.filter_op),
                            $sampled(cfg_out.filter_op));
    assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> cfg_out.filter_mask == exp_head.filter_mask)
        else value_mismatch("cfg_out.filter_mask", $sampled(exp_head.filter_mask),
                            $sampled(cfg_out.filter_mask));
    assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> cfg_out.const_mask == exp_head.const_mask)
        else value_mismatch("cfg_out.const_mask", $sampled(exp_head.const_mask),
                            $sampled(cfg_out.const_mask));
    assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> cfg_out.const_value == exp_head.const_value)
        else value_mismatch("cfg_out.const_value", $sampled(exp_head.const_value),
                            $sampled(cfg_out.const_value));
    assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> cfg_out.ops_mask == exp_head.ops_mask)
        else value_mismatch("cfg_out.ops_mask", $sampled(exp_head.ops_mask),
                            $sampled(cfg_out.ops_mask));
    assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> cfg_out.flags == exp_head.flags)
        else value_mismatch("cfg_out.flags", $sampled(exp_head.flags),
                            $sampled(cfg_out.flags));
    assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> cfg_out.route_if == exp_head.route_if)
        else value_mismatch("cfg_out.route_if", $sampled(exp_head.route_if),
                            $sampled(cfg_out.route_if));
    assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> cfg_out.route_else == exp_head.route_else)
        else value_mismatch("cfg_out.route_else", $sampled(exp_head.route_else),
                            $sampled(cfg_out.route_else));

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        void'($urandom(49));
        ap_clk    = 1'b0;
        rst_n     = 1'b0;
        rsp_valid = 1'b0;
        rsp_pkt   = '0;
        rsp_rd_en = 1'b1;
        cfg_rd_en = 1'b1;
        started   = 1'b0;
        bp_done   = 1'b0;
        cycle_cnt = 0;
        refresh_head();
        repeat (4) @(posedge ap_clk);
        #1;
        rst_n = 1'b1;

        // Quiet outputs after reset
        idle_cycles(10);
        started = 1'b1;

        // One block per setup class
        load_block(`FCFG_CLASS_CU_SETUP, 0, 1'b0);
        wait_drained();
        load_block(`FCFG_CLASS_ENGINE_SETUP, 0, 1'b0);
        wait_drained();

        // Strays alone, then woven into a block
        inject_strays();
        load_block(`FCFG_CLASS_CU_SETUP, 0, 1'b1);
        wait_drained();

        // Offsets scaled by a shift of 3
        load_block(`FCFG_CLASS_ENGINE_SETUP, 3, 1'b0);
        wait_drained();

        // Records pile up while the reader is stalled
        cfg_rd_en = 1'b0;
        fork
            begin
                load_block(`FCFG_CLASS_CU_SETUP, 0, 1'b0);
                load_block(`FCFG_CLASS_ENGINE_SETUP, 2, 1'b1);
                load_block(`FCFG_CLASS_CU_SETUP, 0, 1'b0);
                bp_done = 1'b1;
            end
            begin
                while (!bp_done) begin
                    rsp_rd_en = $urandom % 2;
                    idle_cycles(1);
                end
            end
        join
        rsp_rd_en = 1'b1;
        idle_cycles(64);
        cfg_rd_en = 1'b1;
        wait_drained();

        // Room for a stray record to show up
        idle_cycles(40);
        if (exp_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            plain_failure("expected records still pending at the end");
        end
    end

endmodule

/* filter_cond_cfg.f */
+incdir+common
+incdir+sim
common/mem_pkt_pkg.sv
common/filter_cfg_pkg.sv
design/sync_fifo.sv
cfg_loader/setup_packet_filter.sv
cfg_loader/cfg_word_sequencer.sv
cfg_loader/cfg_field_decoder.sv
cfg_loader/filter_cond_cfg_loader.sv
sim/tb_filter_cond_cfg.sv
